/* source/regbank_pkg.sv */
`default_nettype none

package regbank_pkg;

  // Mode field encodings, low five bits of the status word
  localparam logic [4:0] MODE_USR = 5'b10000;
  localparam logic [4:0] MODE_FIQ = 5'b10001;
  localparam logic [4:0] MODE_IRQ = 5'b10010;
  localparam logic [4:0] MODE_SVC = 5'b10011;
  localparam logic [4:0] MODE_ABT = 5'b10111;
  localparam logic [4:0] MODE_UND = 5'b11011;
  localparam logic [4:0] MODE_SYS = 5'b11111;

  // Status word, seen raw or as fields
  typedef union packed {
    logic [11:0] raw;
    struct packed {
      logic [3:0] flags;    // N Z C V
      logic       irq_mask; // I
      logic       fiq_mask; // F
      logic       thumb;    // T
      logic [4:0] mode;
    } fields;
  } psr_t;

  // Both masks set, ARM state, supervisor
  localparam logic [11:0] PSR_RESET = 12'h0D3;

  // Physical register map
  localparam int NUM_PHYS = 32;
  localparam int DATA_W   = 32;
  localparam logic [4:0] PHYS_PC = 5'd15; // Never stored, reads give pc
  localparam logic [4:0] PHYS_RZ = 5'd31; // Micro-op shadow

  // First physical index of each bank
  localparam logic [4:0] BANK_SVC = 5'd16; // R13/R14 copies
  localparam logic [4:0] BANK_ABT = 5'd18;
  localparam logic [4:0] BANK_UND = 5'd20;
  localparam logic [4:0] BANK_IRQ = 5'd22;
  localparam logic [4:0] BANK_FIQ = 5'd24; // R8..R14 copies

endpackage

`default_nettype wire

/* source/addressdecode.sv */
`default_nettype none

module addressdecode import regbank_pkg::*; (
  input  logic [3:0]          ra1,         // Read port 1 number
  input  logic [3:0]          ra2,         // Read port 2 number
  input  logic [3:0]          wa3,         // Write port number
  input  logic [2:0]          rz_sel,      // Shadow request per port
  input  logic [5:0]          mode_onehot, // {usr_sys, fiq, irq, svc, abt, und}
  output logic [NUM_PHYS-1:0] rsel1,
  output logic [NUM_PHYS-1:0] rsel2,
  output logic [NUM_PHYS-1:0] wsel3
);

  // Architectural number to one-hot physical select
  function automatic logic [NUM_PHYS-1:0] map_reg(
    input logic [3:0] num,
    input logic       rz,
    input logic [5:0] mode_oh
  );
    logic [4:0]          idx;
    logic [4:0]          ofs;
    logic                hit;
    logic [NUM_PHYS-1:0] sel;
    idx = {1'b0, num};        // Default is the identity map
    ofs = {4'b0, ~num[0]};    // R13 -> +0, R14 -> +1
    hit = 1'b1;
    sel = '0;
    if (rz) begin
      // Only R15 has a shadow meaning
      hit = (num == 4'd15);
      idx = PHYS_RZ;
    end else if (mode_oh[4] && (num >= 4'd8) && (num <= 4'd14)) begin
      idx = BANK_FIQ + {2'b0, num[2:0]}; // R8..R14 -> R24..R30
    end else if ((num == 4'd13) || (num == 4'd14)) begin
      if (mode_oh[2]) begin
        idx = BANK_SVC + ofs;
      end else if (mode_oh[1]) begin
        idx = BANK_ABT + ofs;
      end else if (mode_oh[0]) begin
        idx = BANK_UND + ofs;
      end else if (mode_oh[3]) begin
        idx = BANK_IRQ + ofs;
      end
      // usr/sys or unknown mode keep R13/R14
    end
    if (hit) begin
      sel[idx] = 1'b1;
    end
    return sel;
  endfunction

  // Same rules on all three ports
  always_comb begin
    rsel1 = map_reg(ra1, rz_sel[0], mode_onehot);
    rsel2 = map_reg(ra2, rz_sel[1], mode_onehot);
    wsel3 = map_reg(wa3, rz_sel[2], mode_onehot); // Empty when nothing maps
  end

endmodule

`default_nettype wire

/* source/status_register.sv */
`default_nettype none

module status_register import regbank_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       cpsr_we,     // Load new status word
  input  psr_t       cpsr_wd,
  output psr_t       psr,         // Current status word
  output logic [5:0] mode_onehot  // {usr_sys, fiq, irq, svc, abt, und}
);

  logic [4:0] mode;

  // New word visible from the next cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      psr.raw <= PSR_RESET; // Supervisor, interrupts masked
    end else if (cpsr_we) begin
      psr <= cpsr_wd;
    end
  end

  assign mode = psr.fields.mode;

  // Mode flags
  always_comb begin
    mode_onehot[5] = (mode == MODE_USR) || (mode == MODE_SYS); // Same bank
    mode_onehot[4] = (mode == MODE_FIQ);
    mode_onehot[3] = (mode == MODE_IRQ);
    mode_onehot[2] = (mode == MODE_SVC);
    mode_onehot[1] = (mode == MODE_ABT);
    mode_onehot[0] = (mode == MODE_UND);
    // Unlisted encodings leave all flags low
  end

endmodule

`default_nettype wire

/* source/banked_regfile.sv */
`default_nettype none

module banked_regfile import regbank_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic [NUM_PHYS-1:0] rsel1,  // One-hot read select, port 1
  input  logic [NUM_PHYS-1:0] rsel2,  // One-hot read select, port 2
  input  logic [NUM_PHYS-1:0] wsel3,  // One-hot write select
  input  logic                we3,
  input  logic [DATA_W-1:0]   wd3,
  input  logic [DATA_W-1:0]   pc,     // Stands in for R15 on reads
  output logic [DATA_W-1:0]   rd1,
  output logic [DATA_W-1:0]   rd2,
  output logic                pc_we   // Write aimed at R15
);

  logic [DATA_W-1:0] regs [NUM_PHYS];
  logic [DATA_W-1:0] view [NUM_PHYS]; // Storage as seen by the read ports

  // Write port, R15 handled outside
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_PHYS; i++) begin
        regs[i] <= '0;
      end
    end else if (we3) begin
      for (int i = 0; i < NUM_PHYS; i++) begin
        if (wsel3[i] && (i != int'(PHYS_PC))) begin
          regs[i] <= wd3;
        end
      end
    end
  end

  // Program counter replaces entry 15
  always_comb begin
    for (int i = 0; i < NUM_PHYS; i++) begin
      view[i] = (i == int'(PHYS_PC)) ? pc : regs[i];
    end
  end

  // AND-OR read mux, empty select gives zero
  always_comb begin
    rd1 = '0;
    rd2 = '0;
    for (int i = 0; i < NUM_PHYS; i++) begin
      rd1 = rd1 | ({DATA_W{rsel1[i]}} & view[i]);
      rd2 = rd2 | ({DATA_W{rsel2[i]}} & view[i]);
    end
  end

  // No bypass, a same-cycle read sees the old word

  assign pc_we = we3 & wsel3[PHYS_PC]; // Branch request to PC logic

endmodule

`default_nettype wire

/* source/regfile_top.sv */
`default_nettype none

module regfile_top import regbank_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic [3:0]        ra1,     // Architectural read numbers
  input  logic [3:0]        ra2,
  input  logic [3:0]        wa3,     // Architectural write number
  input  logic [2:0]        rz_sel,  // Bit 0 port 1, bit 1 port 2, bit 2 write
  input  logic              we3,
  input  logic [DATA_W-1:0] wd3,
  input  logic [DATA_W-1:0] pc,
  input  logic              cpsr_we,
  input  psr_t              cpsr_wd,
  output logic [DATA_W-1:0] rd1,
  output logic [DATA_W-1:0] rd2,
  output psr_t              cpsr,
  output logic              pc_we
);

  logic [5:0]          mode_onehot; // Current mode, one-hot
  logic [NUM_PHYS-1:0] rsel1;
  logic [NUM_PHYS-1:0] rsel2;
  logic [NUM_PHYS-1:0] wsel3;

  // Status word and mode flags
  status_register i_status (
    .clk         (clk),
    .rst         (rst),
    .cpsr_we     (cpsr_we),
    .cpsr_wd     (cpsr_wd),
    .psr         (cpsr),
    .mode_onehot (mode_onehot)
  );

  // Banking and shadow selection
  addressdecode i_decode (
    .ra1         (ra1),
    .ra2         (ra2),
    .wa3         (wa3),
    .rz_sel      (rz_sel),
    .mode_onehot (mode_onehot),
    .rsel1       (rsel1),
    .rsel2       (rsel2),
    .wsel3       (wsel3)
  );

  // Physical storage
  banked_regfile i_regs (
    .clk   (clk),
    .rst   (rst),
    .rsel1 (rsel1),
    .rsel2 (rsel2),
    .wsel3 (wsel3),
    .we3   (we3),
    .wd3   (wd3),
    .pc    (pc),
    .rd1   (rd1),
    .rd2   (rd2),
    .pc_we (pc_we)
  );

endmodule

`default_nettype wire

/* tb/regfile_tb.sv */
`default_nettype none

module regfile_tb import regbank_pkg::*; ();

  logic        clk;
  logic        rst;
  logic [3:0]  ra1;
  logic [3:0]  ra2;
  logic [3:0]  wa3;
  logic [2:0]  rz_sel;
  logic        we3;
  logic [31:0] wd3;
  logic [31:0] pc;
  logic        cpsr_we;
  psr_t        cpsr_wd;
  logic [31:0] rd1;
  logic [31:0] rd2;
  psr_t        cpsr;
  logic        pc_we;

  logic [31:0] mregs [32];   // Model of the physical registers
  psr_t        mpsr;         // Model status word
  logic [31:0] s_rd1;        // Outputs sampled before the edge
  logic [31:0] s_rd2;
  logic        s_pc_we;
  logic [4:0]  mode_list [7];
  int          errors;
  int          checks;
  int          errors_at_start;
  bit          checking;

  regfile_top i_dut (
    .clk (clk), .rst (rst), .ra1 (ra1), .ra2 (ra2), .wa3 (wa3), .rz_sel (rz_sel),
    .we3 (we3), .wd3 (wd3), .pc (pc), .cpsr_we (cpsr_we), .cpsr_wd (cpsr_wd),
    .rd1 (rd1), .rd2 (rd2), .cpsr (cpsr), .pc_we (pc_we)
  );

  always #5 clk = ~clk;

  // Architectural number to physical index or -1 when nothing maps
  function automatic int phys_index(input logic [3:0] num, input logic rz,
                                    input logic [4:0] mode);
    int base;
    if (rz) return (num == 4'd15) ? 31 : -1;   // Only R15 has a shadow
    if (num < 4'd8 || num == 4'd15) return int'(num);
    if (mode == MODE_FIQ) return 16 + int'(num); // R8..R14 -> R24..R30
    if (num < 4'd13) return int'(num);
    case (mode)
      MODE_SVC: base = 16;
      MODE_ABT: base = 18;
      MODE_UND: base = 20;
      MODE_IRQ: base = 22;
      default:  return int'(num);               // usr, sys, unlisted
    endcase
    return base + int'(num) - 13;
  endfunction

  function automatic logic [31:0] model_read(input logic [3:0] num, input logic rz);
    int idx;
    idx = phys_index(num, rz, mpsr.fields.mode);
    if (idx < 0) return 32'd0;
    if (idx == 15) return pc;                   // PC comes from outside
    return mregs[idx];
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %s got %h expected %h", name, got, exp);
    end
  endtask

  // One clock cycle that samples, compares and then steps the model at the edge
  task automatic tick();
    int  widx;
    logic exp_we;
    pc = $urandom();
    #8;
    s_rd1   = rd1;
    s_rd2   = rd2;
    s_pc_we = pc_we;
    if (checking) begin
      widx   = phys_index(wa3, rz_sel[2], mpsr.fields.mode);
      exp_we = we3 && (widx == 15);
      check("rd1", rd1, model_read(ra1, rz_sel[0]));
      check("rd2", rd2, model_read(ra2, rz_sel[1]));
      check("pc_we", 32'(pc_we), 32'(exp_we));
      check("cpsr", 32'(cpsr.raw), 32'(mpsr.raw));
    end
    @(posedge clk);
    if (rst) begin
      foreach (mregs[i]) mregs[i] = '0;
      mpsr.raw = 12'h0D3;
    end else begin
      widx = phys_index(wa3, rz_sel[2], mpsr.fields.mode); // Old mode still decodes
      if (we3 && widx >= 0 && widx != 15) mregs[widx] = wd3;
      if (cpsr_we) mpsr = cpsr_wd;
    end
    #1;                                         // Drive point after the edge
  endtask

  task automatic set_mode(input logic [4:0] mode);
    cpsr_wd.raw = {4'h0, 3'b110, mode};         // Masks set in ARM state
    cpsr_we = 1'b1;
    tick();
    cpsr_we = 1'b0;
  endtask

  task automatic write_reg(input logic [3:0] num, input logic rz, input logic [31:0] data);
    wa3    = num;
    rz_sel = {rz, 2'b00};
    wd3    = data;
    we3    = 1'b1;
    tick();
    we3    = 1'b0;
    rz_sel = 3'b000;
  endtask

  task automatic read_regs(input logic [3:0] a1, input logic z1,
                           input logic [3:0] a2, input logic z2);
    ra1    = a1;
    ra2    = a2;
    rz_sel = {1'b0, z2, z1};
    we3    = 1'b0;
    tick();
    rz_sel = 3'b000;
  endtask

  task automatic end_test(input int num, input string name);
    $display("test %0d %s: %0d mismatches", num, name, errors - errors_at_start);
    errors_at_start = errors;
  endtask

  initial begin
    logic [31:0] vals [15];
    logic [31:0] b13 [7];
    logic [31:0] b14 [7];
    logic [31:0] fvals [5];
    logic [31:0] zval;
    void'($urandom(32'h76aaa9b0));
    clk = 1'b0;
    rst = 1'b1;
    ra1 = '0;
    ra2 = '0;
    wa3 = '0;
    rz_sel = '0;
    we3 = 1'b0;
    wd3 = '0;
    pc = '0;
    cpsr_we = 1'b0;
    cpsr_wd.raw = '0;
    mode_list = '{MODE_USR, MODE_FIQ, MODE_IRQ, MODE_SVC, MODE_ABT, MODE_UND,
                  MODE_SYS};                    // System shares the user pair
    foreach (mregs[i]) mregs[i] = '0;
    mpsr.raw = 12'h0D3;
    errors = 0;
    checks = 0;
    errors_at_start = 0;
    checking = 1'b0;
    @(posedge clk);
    #1;
    repeat (3) tick();                          // Four reset edges in all
    rst = 1'b0;
    checking = 1'b1;

    // Reset state in supervisor mode
    check("cpsr", 32'(cpsr.raw), 32'h0D3);
    for (int i = 0; i < 16; i++) begin
      read_regs(4'(i), 1'b0, 4'(15 - i), 1'b0);
      check("rd1", s_rd1, (i == 15) ? pc : 32'd0);
      check("rd2", s_rd2, (i == 0) ? pc : 32'd0);
    end
    end_test(1, "reset");

    // Shared registers in user mode
    set_mode(MODE_USR);
    for (int i = 0; i < 15; i++) begin
      vals[i] = $urandom();
      write_reg(4'(i), 1'b0, vals[i]);
    end
    for (int i = 0; i < 15; i++) begin
      read_regs(4'(i), 1'b0, 4'(i), 1'b0);
      check("rd1", s_rd1, vals[i]);
      check("rd2", s_rd2, vals[i]);
    end
    write_reg(4'd15, 1'b0, $urandom());
    check("pc_we", 32'(s_pc_we), 32'd1);        // Branch strobe instead of a store
    read_regs(4'd15, 1'b0, 4'd15, 1'b0);
    check("rd1", s_rd1, pc);
    end_test(2, "shared_registers");

    // R13/R14 per mode tagged by mode index
    for (int i = 0; i < 6; i++) begin
      set_mode(mode_list[i]);
      b13[i] = {8'(i), 8'h0D, 16'($urandom())};
      b14[i] = {8'(i), 8'h0E, 16'($urandom())};
      write_reg(4'd13, 1'b0, b13[i]);
      write_reg(4'd14, 1'b0, b14[i]);
    end
    for (int i = 0; i < 7; i++) begin
      set_mode(mode_list[i]);
      read_regs(4'd13, 1'b0, 4'd14, 1'b0);
      check("rd1", s_rd1, b13[(i == 6) ? 0 : i]);
      check("rd2", s_rd2, b14[(i == 6) ? 0 : i]);
    end
    end_test(3, "r13_r14_banking");

    // FIQ copies of R8..R12
    set_mode(MODE_USR);
    for (int i = 0; i < 5; i++) begin
      vals[i + 8] = $urandom();
      write_reg(4'(i + 8), 1'b0, vals[i + 8]);
    end
    set_mode(MODE_FIQ);
    for (int i = 0; i < 5; i++) begin
      fvals[i] = ~vals[i + 8];                  // Never equal to the user value
      write_reg(4'(i + 8), 1'b0, fvals[i]);
    end
    for (int i = 0; i < 5; i++) begin
      read_regs(4'(i + 8), 1'b0, 4'(i + 8), 1'b0);
      check("rd1", s_rd1, fvals[i]);
    end
    set_mode(MODE_USR);
    for (int i = 0; i < 5; i++) begin
      read_regs(4'(i + 8), 1'b0, 4'(i + 8), 1'b0);
      check("rd2", s_rd2, vals[i + 8]);
    end
    end_test(4, "fiq_banking");

    // Shadow register R31
    set_mode(MODE_SVC);
    zval = $urandom();
    write_reg(4'd15, 1'b1, zval);
    check("pc_we", 32'(s_pc_we), 32'd0);
    read_regs(4'd15, 1'b1, 4'd15, 1'b0);
    check("rd1", s_rd1, zval);
    check("rd2", s_rd2, pc);
    for (int i = 0; i < 15; i++) begin
      read_regs(4'(i), 1'b1, 4'(i), 1'b1);      // Unmapped so reads zero
      check("rd1", s_rd1, 32'd0);
      check("rd2", s_rd2, 32'd0);
    end
    write_reg(4'd3, 1'b1, $urandom());          // Dropped writes
    write_reg(4'd13, 1'b1, $urandom());
    for (int m = 0; m < 7; m++) begin
      set_mode(mode_list[m]);
      for (int i = 0; i < 15; i++) read_regs(4'(i), 1'b0, 4'(14 - i), 1'b0);
      read_regs(4'd15, 1'b1, 4'd15, 1'b1);
      check("rd1", s_rd1, zval);
      check("rd2", s_rd2, zval);
    end
    end_test(5, "shadow_register");

    // Random traffic with a model compare every cycle
    for (int c = 0; c < 2000; c++) begin
      ra1 = 4'($urandom());
      ra2 = 4'($urandom());
      wa3 = 4'($urandom());
      rz_sel = 3'($urandom()) & 3'($urandom()) & 3'($urandom()); // Rare Rz bits
      we3 = 1'($urandom());
      wd3 = $urandom();
      cpsr_we = ($urandom() % 16) == 0;
      cpsr_wd.raw = {7'($urandom()), mode_list[$urandom() % 7]};
      tick();
    end
    we3 = 1'b0;
    cpsr_we = 1'b0;
    rz_sel = 3'b000;
    end_test(6, "random_mix");

    $display("tests 6, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* regfile_top.f */
source/regbank_pkg.sv
source/addressdecode.sv
source/status_register.sv
source/banked_regfile.sv
source/regfile_top.sv
tb/regfile_tb.sv

/* Makefile */
# Verilator build and run of the register file testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --top-module regfile_tb -f regfile_top.f -o sim_regfile
	./obj_dir/sim_regfile | tee sim.log
	@if grep -q "sim failed" sim.log; then \
	  echo "Result: FAIL"; exit 1; \
	elif ! grep -q "sim passed" sim.log; then \
	  echo "Result: FAIL, run did not complete"; exit 1; \
	else \
	  echo "Result: PASS"; \
	fi

clean:
	rm -rf obj_dir sim.log
